// ==== hw/decode_cfg.svh ====
`ifndef DECODE_CFG_SVH
`define DECODE_CFG_SVH

// instruction memory port.
`define IMEM_AW 32
`define IMEM_DW 32

// trace memory port, one 64-bit record per beat.
`define TRACE_AW 32
`define TRACE_DW 64
`define TRACE_SEL_W 8
`define TRACE_BASE 32'h0001_0000

`define COUNT_W 16

`endif

// ==== hw/decode_pkg.sv ====
`default_nettype none

package decode_pkg;

	typedef logic [31:0] insn_t;
	typedef logic [4:0] reg_idx_t;
	typedef logic [31:0] imm_t;
	typedef logic [2:0] fmt_t;
	typedef logic [6:0] mnem_t;
	typedef logic [2:0] flags_t;
	typedef logic [63:0] trace_rec_t;

	localparam fmt_t FMT_R = 3'd0;
	localparam fmt_t FMT_I = 3'd1;
	localparam fmt_t FMT_S = 3'd2;
	localparam fmt_t FMT_B = 3'd3;
	localparam fmt_t FMT_U = 3'd4;
	localparam fmt_t FMT_J = 3'd5;
	localparam fmt_t FMT_NONE = 3'd7; // system and unknown words.

	localparam int FLAG_LOAD = 2;
	localparam int FLAG_MEM = 1;
	localparam int FLAG_SIGNED = 0;

	localparam mnem_t
		MN_UNKNOWN = 7'd0, MN_LUI = 7'd1, MN_AUIPC = 7'd2, MN_JAL = 7'd3,
		MN_JALR = 7'd4, MN_BEQ = 7'd5, MN_BNE = 7'd6, MN_BLT = 7'd7,
		MN_BGE = 7'd8, MN_BLTU = 7'd9, MN_BGEU = 7'd10, MN_LB = 7'd11,
		MN_LH = 7'd12, MN_LW = 7'd13, MN_LD = 7'd14, MN_LBU = 7'd15,
		MN_LHU = 7'd16, MN_LWU = 7'd17, MN_SB = 7'd18, MN_SH = 7'd19,
		MN_SW = 7'd20, MN_SD = 7'd21, MN_ADDI = 7'd22, MN_SLTI = 7'd23,
		MN_SLTIU = 7'd24, MN_XORI = 7'd25, MN_ORI = 7'd26, MN_ANDI = 7'd27,
		MN_SLLI = 7'd28, MN_SRLI = 7'd29, MN_SRAI = 7'd30, MN_ADDIW = 7'd31,
		MN_SLLIW = 7'd32, MN_SRLIW = 7'd33, MN_SRAIW = 7'd34, MN_ADD = 7'd35,
		MN_SUB = 7'd36, MN_SLL = 7'd37, MN_SLT = 7'd38, MN_SLTU = 7'd39,
		MN_XOR = 7'd40, MN_SRL = 7'd41, MN_SRA = 7'd42, MN_OR = 7'd43,
		MN_AND = 7'd44, MN_ADDW = 7'd45, MN_SUBW = 7'd46, MN_SLLW = 7'd47,
		MN_SRLW = 7'd48, MN_SRAW = 7'd49, MN_MUL = 7'd50, MN_MULH = 7'd51,
		MN_MULHSU = 7'd52, MN_MULHU = 7'd53, MN_DIV = 7'd54, MN_DIVU = 7'd55,
		MN_REM = 7'd56, MN_REMU = 7'd57, MN_MULW = 7'd58, MN_DIVW = 7'd59,
		MN_DIVUW = 7'd60, MN_REMW = 7'd61, MN_REMUW = 7'd62, MN_SYSTEM = 7'd63;

	// the record holds 4 zero bits on top, then id, format, flags, rd, rs1, rs2 and immediate.
	function automatic trace_rec_t pack_rec(input mnem_t mnem, input fmt_t fmt,
		input flags_t flags, input reg_idx_t rd, input reg_idx_t rs1,
		input reg_idx_t rs2, input imm_t imm);
		pack_rec = {4'b0000, mnem, fmt, flags, rd, rs1, rs2, imm};
	endfunction

endpackage

`default_nettype wire

// ==== hw/insn_fetch.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "decode_cfg.svh"

module insn_fetch
(
	input wire clk,
	input wire rst_n,
	input wire start,
	input wire [`IMEM_AW-1:0] start_addr,
	input wire [`COUNT_W-1:0] insn_count,
	input wire done,
	output logic imem_cyc,
	output logic imem_stb,
	output logic imem_we,
	output logic [`IMEM_AW-1:0] imem_adr,
	input wire [`IMEM_DW-1:0] imem_dat_r,
	input wire imem_ack,
	output logic word_valid,
	output decode_pkg::insn_t word,
	output logic word_last,
	input wire word_ready,
	output logic busy
);

	typedef enum logic [1:0] {IDLE, READ, HOLD_WAIT} fetch_state_t;

	fetch_state_t state;
	logic busy_r;
	logic [`COUNT_W-1:0] remaining;
	logic [`IMEM_AW-1:0] adr;
	logic launch;
	logic fill;
	logic take;

	assign busy = busy_r && !done; // falls in the same cycle as done.
	assign launch = (state == IDLE) && start && !busy;
	assign fill = (state == READ) && imem_ack;
	assign take = word_valid && word_ready;

	assign imem_cyc = (state == READ);
	assign imem_stb = (state == READ);
	assign imem_we = 1'b0;
	assign imem_adr = adr;

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			state <= IDLE;
			busy_r <= 1'b0;
			remaining <= '0;
			word_valid <= 1'b0;
			word_last <= 1'b0;
		end
		else
		begin
			if (done)
				busy_r <= 1'b0;
			if (take)
				word_valid <= 1'b0;
			case (state)
				IDLE:
					if (launch)
					begin
						busy_r <= 1'b1;
						remaining <= insn_count;
						state <= (insn_count != '0) ? READ : IDLE; // an empty run stays idle.
					end
				READ:
					if (imem_ack)
					begin
						word_valid <= 1'b1;
						word_last <= (remaining == `COUNT_W'(1));
						remaining <= remaining - `COUNT_W'(1);
						state <= (remaining == `COUNT_W'(1)) ? IDLE : HOLD_WAIT;
					end
				HOLD_WAIT:
					if (take)
						state <= READ; // next read only once the held word moves on.
				default:
					state <= IDLE;
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if (launch)
			adr <= start_addr;
		else if (fill)
			adr <= adr + `IMEM_AW'(4);
		if (fill)
			word <= imem_dat_r;
	end

endmodule

`default_nettype wire

// ==== hw/insn_classify.sv ====
`timescale 1ns/1ps
`default_nettype none

module insn_classify
(
	input wire decode_pkg::insn_t word,
	output decode_pkg::fmt_t fmt,
	output decode_pkg::mnem_t mnem,
	output decode_pkg::flags_t flags
);

	import decode_pkg::*;

	logic [6:0] opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;
	logic [5:0] funct6;
	fmt_t fmt_sel;

	assign opcode = word[6:0];
	assign funct3 = word[14:12];
	assign funct7 = word[31:25];
	assign funct6 = word[31:26];

	always_comb
	begin
		fmt_sel = FMT_NONE;
		mnem = MN_UNKNOWN;
		case (opcode)
			7'b0110111:
			begin
				fmt_sel = FMT_U;
				mnem = MN_LUI;
			end
			7'b0010111:
			begin
				fmt_sel = FMT_U;
				mnem = MN_AUIPC;
			end
			7'b1101111:
			begin
				fmt_sel = FMT_J;
				mnem = MN_JAL;
			end
			7'b1100111:
			begin
				fmt_sel = FMT_I;
				if (funct3 == 3'b000)
					mnem = MN_JALR;
			end
			7'b1100011:
			begin
				fmt_sel = FMT_B;
				case (funct3)
					3'b000: mnem = MN_BEQ;
					3'b001: mnem = MN_BNE;
					3'b100: mnem = MN_BLT;
					3'b101: mnem = MN_BGE;
					3'b110: mnem = MN_BLTU;
					3'b111: mnem = MN_BGEU;
				endcase
			end
			7'b0000011:
			begin
				fmt_sel = FMT_I;
				case (funct3)
					3'b000: mnem = MN_LB;
					3'b001: mnem = MN_LH;
					3'b010: mnem = MN_LW;
					3'b011: mnem = MN_LD;
					3'b100: mnem = MN_LBU;
					3'b101: mnem = MN_LHU;
					3'b110: mnem = MN_LWU;
				endcase
			end
			7'b0100011:
			begin
				fmt_sel = FMT_S;
				case (funct3)
					3'b000: mnem = MN_SB;
					3'b001: mnem = MN_SH;
					3'b010: mnem = MN_SW;
					3'b011: mnem = MN_SD;
				endcase
			end
			7'b0010011:
			begin
				fmt_sel = FMT_I;
				case (funct3)
					3'b000: mnem = MN_ADDI;
					3'b010: mnem = MN_SLTI;
					3'b011: mnem = MN_SLTIU;
					3'b100: mnem = MN_XORI;
					3'b110: mnem = MN_ORI;
					3'b111: mnem = MN_ANDI;
					3'b001: mnem = (funct6 == 6'b000000) ? MN_SLLI : MN_UNKNOWN;
					3'b101:
						if (funct6 == 6'b000000)
							mnem = MN_SRLI;
						else if (funct6 == 6'b010000)
							mnem = MN_SRAI;
				endcase
			end
			7'b0011011:
			begin
				fmt_sel = FMT_I; // the word forms keep a 5-bit shift amount.
				case (funct3)
					3'b000: mnem = MN_ADDIW;
					3'b001: mnem = (funct7 == 7'b0000000) ? MN_SLLIW : MN_UNKNOWN;
					3'b101:
						if (funct7 == 7'b0000000)
							mnem = MN_SRLIW;
						else if (funct7 == 7'b0100000)
							mnem = MN_SRAIW;
				endcase
			end
			7'b0110011:
			begin
				fmt_sel = FMT_R;
				case ({funct7, funct3})
					10'b0000000_000: mnem = MN_ADD;
					10'b0100000_000: mnem = MN_SUB;
					10'b0000000_001: mnem = MN_SLL;
					10'b0000000_010: mnem = MN_SLT;
					10'b0000000_011: mnem = MN_SLTU;
					10'b0000000_100: mnem = MN_XOR;
					10'b0000000_101: mnem = MN_SRL;
					10'b0100000_101: mnem = MN_SRA;
					10'b0000000_110: mnem = MN_OR;
					10'b0000000_111: mnem = MN_AND;
					10'b0000001_000: mnem = MN_MUL;
					10'b0000001_001: mnem = MN_MULH;
					10'b0000001_010: mnem = MN_MULHSU;
					10'b0000001_011: mnem = MN_MULHU;
					10'b0000001_100: mnem = MN_DIV;
					10'b0000001_101: mnem = MN_DIVU;
					10'b0000001_110: mnem = MN_REM;
					10'b0000001_111: mnem = MN_REMU;
				endcase
			end
			7'b0111011:
			begin
				fmt_sel = FMT_R;
				case ({funct7, funct3})
					10'b0000000_000: mnem = MN_ADDW;
					10'b0100000_000: mnem = MN_SUBW;
					10'b0000000_001: mnem = MN_SLLW;
					10'b0000000_101: mnem = MN_SRLW;
					10'b0100000_101: mnem = MN_SRAW;
					10'b0000001_000: mnem = MN_MULW;
					10'b0000001_100: mnem = MN_DIVW;
					10'b0000001_101: mnem = MN_DIVUW;
					10'b0000001_110: mnem = MN_REMW;
					10'b0000001_111: mnem = MN_REMUW;
				endcase
			end
			7'b0001111:
				if (funct3 == 3'b000 || funct3 == 3'b001)
					mnem = MN_SYSTEM; // fence and fence.i.
			7'b1110011:
				if (word == 32'h0000_0073 || word == 32'h0010_0073)
					mnem = MN_SYSTEM;
				else if (funct3 == 3'b010 && word[19:15] == 5'd0
					&& word[31:20] inside {12'hc00, 12'hc01, 12'hc02, 12'hc80, 12'hc81, 12'hc82})
					mnem = MN_SYSTEM; // the counter reads, csrrs with rs1 of zero.
			default:
				mnem = MN_UNKNOWN;
		endcase

		fmt = (mnem == MN_UNKNOWN) ? FMT_NONE : fmt_sel;

		flags[FLAG_LOAD] = mnem inside {MN_LB, MN_LH, MN_LW, MN_LD, MN_LBU, MN_LHU, MN_LWU};
		flags[FLAG_MEM] = flags[FLAG_LOAD] || (mnem inside {MN_SB, MN_SH, MN_SW, MN_SD});
		flags[FLAG_SIGNED] = !(mnem inside {MN_BLTU, MN_BGEU, MN_SLTU, MN_SLTIU, MN_LBU,
			MN_LHU, MN_LWU, MN_MULHSU, MN_MULHU, MN_DIVU, MN_REMU, MN_DIVUW, MN_REMUW});
	end

endmodule

`default_nettype wire

// ==== hw/operand_extract.sv ====
`timescale 1ns/1ps
`default_nettype none

module operand_extract
(
	input wire decode_pkg::insn_t word,
	input wire decode_pkg::fmt_t fmt,
	output decode_pkg::reg_idx_t rd,
	output decode_pkg::reg_idx_t rs1,
	output decode_pkg::reg_idx_t rs2,
	output decode_pkg::imm_t imm
);

	import decode_pkg::*;

	always_comb
	begin
		rd = word[11:7];
		rs1 = word[19:15];
		rs2 = word[24:20];
		imm = '0;
		case (fmt)
			FMT_R:
				imm = '0;
			FMT_I:
			begin
				rs2 = '0;
				imm = {{20{word[31]}}, word[31:20]};
			end
			FMT_S:
			begin
				rd = '0;
				imm = {{20{word[31]}}, word[31:25], word[11:7]};
			end
			FMT_B:
			begin
				rd = '0;
				imm = {{20{word[31]}}, word[7], word[30:25], word[11:8], 1'b0}; // bit 0 is always clear.
			end
			FMT_U:
			begin
				rs1 = '0;
				rs2 = '0;
				imm = {word[31:12], 12'h000};
			end
			FMT_J:
			begin
				rs1 = '0;
				rs2 = '0;
				imm = {{12{word[31]}}, word[19:12], word[20], word[30:21], 1'b0};
			end
			default:
			begin
				rd = '0; // nothing to extract from system or unknown words.
				rs1 = '0;
				rs2 = '0;
			end
		endcase
	end

endmodule

`default_nettype wire

// ==== hw/trace_writer.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "decode_cfg.svh"

module trace_writer
(
	input wire clk,
	input wire rst_n,
	input wire word_valid,
	input wire word_last,
	output logic word_ready,
	input wire decode_pkg::fmt_t fmt,
	input wire decode_pkg::mnem_t mnem,
	input wire decode_pkg::flags_t flags,
	input wire decode_pkg::reg_idx_t rd,
	input wire decode_pkg::reg_idx_t rs1,
	input wire decode_pkg::reg_idx_t rs2,
	input wire decode_pkg::imm_t imm,
	output logic trc_cyc,
	output logic trc_stb,
	output logic trc_we,
	output logic [`TRACE_AW-1:0] trc_adr,
	output logic [`TRACE_SEL_W-1:0] trc_sel,
	output logic [`TRACE_DW-1:0] trc_dat_w,
	input wire trc_ack,
	output logic done
);

	import decode_pkg::*;

	trace_rec_t rec;
	logic rec_valid;
	logic rec_last;
	logic [`COUNT_W-1:0] index;
	logic [`TRACE_AW-1:0] adr;
	logic take;
	logic finish;

	assign word_ready = !rec_valid || trc_ack; // a record leaving frees the slot at once.
	assign take = word_valid && word_ready;
	assign finish = rec_valid && trc_ack && rec_last;

	assign trc_cyc = rec_valid;
	assign trc_stb = rec_valid;
	assign trc_we = rec_valid;
	assign trc_adr = adr;
	assign trc_sel = '1;
	assign trc_dat_w = rec;

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			rec_valid <= 1'b0;
			rec_last <= 1'b0;
			index <= '0;
			done <= 1'b0;
		end
		else
		begin
			done <= finish;
			if (take)
			begin
				rec_valid <= 1'b1;
				rec_last <= word_last;
				index <= index + `COUNT_W'(1);
			end
			else if (rec_valid && trc_ack)
				rec_valid <= 1'b0;
			if (finish)
				index <= '0; // the next run starts again at the base.
		end
	end

	always_ff @(posedge clk)
	begin
		if (take)
		begin
			rec <= pack_rec(mnem, fmt, flags, rd, rs1, rs2, imm);
			adr <= `TRACE_BASE + `TRACE_AW'({index, 3'b000});
		end
	end

endmodule

`default_nettype wire

// ==== hw/insn_decode_top.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "decode_cfg.svh"

module insn_decode_top
(
	input wire clk,
	input wire rst_n,
	input wire start,
	input wire [`IMEM_AW-1:0] start_addr,
	input wire [`COUNT_W-1:0] insn_count,
	output logic busy,
	output logic done,
	output logic imem_cyc,
	output logic imem_stb,
	output logic imem_we,
	output logic [`IMEM_AW-1:0] imem_adr,
	input wire [`IMEM_DW-1:0] imem_dat_r,
	input wire imem_ack,
	output logic trc_cyc,
	output logic trc_stb,
	output logic trc_we,
	output logic [`TRACE_AW-1:0] trc_adr,
	output logic [`TRACE_SEL_W-1:0] trc_sel,
	output logic [`TRACE_DW-1:0] trc_dat_w,
	input wire trc_ack
);

	import decode_pkg::*;

	insn_t word;
	logic word_valid;
	logic word_last;
	logic word_ready;
	fmt_t fmt;
	mnem_t mnem;
	flags_t flags;
	reg_idx_t rd;
	reg_idx_t rs1;
	reg_idx_t rs2;
	imm_t imm;
	logic wr_done;
	logic zero_q;
	logic zero_done;

	// an empty run never reaches the writer, so its done comes from here.
	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			zero_q <= 1'b0;
			zero_done <= 1'b0;
		end
		else
		begin
			zero_q <= start && !busy && (insn_count == '0);
			zero_done <= zero_q;
		end
	end

	assign done = wr_done || zero_done;

	insn_fetch u_fetch (.*);

	insn_classify u_classify (.*);

	operand_extract u_extract (.*);

	trace_writer u_writer (.*, .done(wr_done));

endmodule

`default_nettype wire

// ==== verification/insn_decode_props.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "decode_cfg.svh"

module insn_decode_props
(
	input wire clk,
	input wire rst_n,
	input wire busy,
	input wire done,
	input wire imem_cyc,
	input wire imem_stb,
	input wire [`IMEM_AW-1:0] imem_adr,
	input wire imem_ack,
	input wire trc_cyc,
	input wire trc_stb,
	input wire [`TRACE_AW-1:0] trc_adr,
	input wire [`TRACE_DW-1:0] trc_dat_w,
	input wire trc_ack
);

	int fail_count = 0;

	imem_hold: assert property (@(posedge clk) disable iff (!rst_n)
		imem_stb && !imem_ack |=> imem_cyc && imem_stb && $stable(imem_adr))
		else
		begin
			fail_count = fail_count + 1;
			$error("instruction read dropped or changed before its ack");
		end

	trc_hold: assert property (@(posedge clk) disable iff (!rst_n)
		trc_stb && !trc_ack |=> trc_cyc && trc_stb && $stable(trc_adr) && $stable(trc_dat_w))
		else
		begin
			fail_count = fail_count + 1;
			$error("trace write dropped or changed before its ack");
		end

	done_pulse: assert property (@(posedge clk) disable iff (!rst_n) done |=> !done)
		else
		begin
			fail_count = fail_count + 1;
			$error("done held for more than one cycle");
		end

	busy_reset: assert property (@(posedge clk) !rst_n |=> !busy)
		else
		begin
			fail_count = fail_count + 1;
			$error("busy high after reset");
		end

endmodule

bind insn_decode_top insn_decode_props u_props (.*);

`default_nettype wire

// ==== verification/tb_insn_decode.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "decode_cfg.svh"

module tb_insn_decode;

	import decode_pkg::*;

	localparam int CLK_PERIOD = 20;
	localparam int TOTAL_WORDS = 102; // sum of the run lengths below.

	logic clk;
	logic rst_n;
	logic start;
	logic [`IMEM_AW-1:0] start_addr;
	logic [`COUNT_W-1:0] insn_count;
	logic busy;
	logic done;
	logic imem_cyc;
	logic imem_stb;
	logic imem_we;
	logic [`IMEM_AW-1:0] imem_adr;
	logic [`IMEM_DW-1:0] imem_dat_r = '0;
	logic imem_ack = 1'b0;
	logic trc_cyc;
	logic trc_stb;
	logic trc_we;
	logic [`TRACE_AW-1:0] trc_adr;
	logic [`TRACE_SEL_W-1:0] trc_sel;
	logic [`TRACE_DW-1:0] trc_dat_w;
	logic trc_ack = 1'b0;

	logic [31:0] lfsr = 32'h6011701b;
	logic [31:0] mem [0:255];
	trace_rec_t exp_rec [0:255];
	logic [1:0] rd_delay [0:511];
	logic [1:0] wr_delay [0:511];
	logic [31:0] run_start;
	int run_count;
	int rd_base;
	int wr_base;
	int rd_count = 0;
	int wr_count = 0;
	logic [1:0] rd_wait;
	logic [1:0] wr_wait;
	int err_rd = 0;
	int err_wr = 0;
	int err_ctl = 0;

	insn_decode_top DUT (.*);

	always #(CLK_PERIOD / 2) clk = ~clk;

	function automatic logic [31:0] take_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int k = 0; k < n; k++)
		begin
			v = {v[30:0], lfsr[0]};
			lfsr = (lfsr >> 1) ^ (lfsr[0] ? 32'h80200003 : 32'h0); // galois step.
		end
		return v;
	endfunction

	// {match kind, format, funct7, funct3, opcode}; kind 0 opcode, 1 +funct3, 2 +funct7, 3 +funct6.
	function automatic logic [21:0] encoding_of(input mnem_t m);
		case (m)
			MN_LUI: return {2'd0, FMT_U, 7'h00, 3'd0, 7'h37};
			MN_AUIPC: return {2'd0, FMT_U, 7'h00, 3'd0, 7'h17};
			MN_JAL: return {2'd0, FMT_J, 7'h00, 3'd0, 7'h6f};
			MN_JALR: return {2'd1, FMT_I, 7'h00, 3'd0, 7'h67};
			MN_BEQ: return {2'd1, FMT_B, 7'h00, 3'd0, 7'h63};
			MN_BNE: return {2'd1, FMT_B, 7'h00, 3'd1, 7'h63};
			MN_BLT: return {2'd1, FMT_B, 7'h00, 3'd4, 7'h63};
			MN_BGE: return {2'd1, FMT_B, 7'h00, 3'd5, 7'h63};
			MN_BLTU: return {2'd1, FMT_B, 7'h00, 3'd6, 7'h63};
			MN_BGEU: return {2'd1, FMT_B, 7'h00, 3'd7, 7'h63};
			MN_LB: return {2'd1, FMT_I, 7'h00, 3'd0, 7'h03};
			MN_LH: return {2'd1, FMT_I, 7'h00, 3'd1, 7'h03};
			MN_LW: return {2'd1, FMT_I, 7'h00, 3'd2, 7'h03};
			MN_LD: return {2'd1, FMT_I, 7'h00, 3'd3, 7'h03};
			MN_LBU: return {2'd1, FMT_I, 7'h00, 3'd4, 7'h03};
			MN_LHU: return {2'd1, FMT_I, 7'h00, 3'd5, 7'h03};
			MN_LWU: return {2'd1, FMT_I, 7'h00, 3'd6, 7'h03};
			MN_SB: return {2'd1, FMT_S, 7'h00, 3'd0, 7'h23};
			MN_SH: return {2'd1, FMT_S, 7'h00, 3'd1, 7'h23};
			MN_SW: return {2'd1, FMT_S, 7'h00, 3'd2, 7'h23};
			MN_SD: return {2'd1, FMT_S, 7'h00, 3'd3, 7'h23};
			MN_ADDI: return {2'd1, FMT_I, 7'h00, 3'd0, 7'h13};
			MN_SLTI: return {2'd1, FMT_I, 7'h00, 3'd2, 7'h13};
			MN_SLTIU: return {2'd1, FMT_I, 7'h00, 3'd3, 7'h13};
			MN_XORI: return {2'd1, FMT_I, 7'h00, 3'd4, 7'h13};
			MN_ORI: return {2'd1, FMT_I, 7'h00, 3'd6, 7'h13};
			MN_ANDI: return {2'd1, FMT_I, 7'h00, 3'd7, 7'h13};
			MN_SLLI: return {2'd3, FMT_I, 7'h00, 3'd1, 7'h13};
			MN_SRLI: return {2'd3, FMT_I, 7'h00, 3'd5, 7'h13};
			MN_SRAI: return {2'd3, FMT_I, 7'h20, 3'd5, 7'h13};
			MN_ADDIW: return {2'd1, FMT_I, 7'h00, 3'd0, 7'h1b};
			MN_SLLIW: return {2'd2, FMT_I, 7'h00, 3'd1, 7'h1b};
			MN_SRLIW: return {2'd2, FMT_I, 7'h00, 3'd5, 7'h1b};
			MN_SRAIW: return {2'd2, FMT_I, 7'h20, 3'd5, 7'h1b};
			MN_ADD: return {2'd2, FMT_R, 7'h00, 3'd0, 7'h33};
			MN_SUB: return {2'd2, FMT_R, 7'h20, 3'd0, 7'h33};
			MN_SLL: return {2'd2, FMT_R, 7'h00, 3'd1, 7'h33};
			MN_SLT: return {2'd2, FMT_R, 7'h00, 3'd2, 7'h33};
			MN_SLTU: return {2'd2, FMT_R, 7'h00, 3'd3, 7'h33};
			MN_XOR: return {2'd2, FMT_R, 7'h00, 3'd4, 7'h33};
			MN_SRL: return {2'd2, FMT_R, 7'h00, 3'd5, 7'h33};
			MN_SRA: return {2'd2, FMT_R, 7'h20, 3'd5, 7'h33};
			MN_OR: return {2'd2, FMT_R, 7'h00, 3'd6, 7'h33};
			MN_AND: return {2'd2, FMT_R, 7'h00, 3'd7, 7'h33};
			MN_MUL: return {2'd2, FMT_R, 7'h01, 3'd0, 7'h33};
			MN_MULH: return {2'd2, FMT_R, 7'h01, 3'd1, 7'h33};
			MN_MULHSU: return {2'd2, FMT_R, 7'h01, 3'd2, 7'h33};
			MN_MULHU: return {2'd2, FMT_R, 7'h01, 3'd3, 7'h33};
			MN_DIV: return {2'd2, FMT_R, 7'h01, 3'd4, 7'h33};
			MN_DIVU: return {2'd2, FMT_R, 7'h01, 3'd5, 7'h33};
			MN_REM: return {2'd2, FMT_R, 7'h01, 3'd6, 7'h33};
			MN_REMU: return {2'd2, FMT_R, 7'h01, 3'd7, 7'h33};
			MN_ADDW: return {2'd2, FMT_R, 7'h00, 3'd0, 7'h3b};
			MN_SUBW: return {2'd2, FMT_R, 7'h20, 3'd0, 7'h3b};
			MN_SLLW: return {2'd2, FMT_R, 7'h00, 3'd1, 7'h3b};
			MN_SRLW: return {2'd2, FMT_R, 7'h00, 3'd5, 7'h3b};
			MN_SRAW: return {2'd2, FMT_R, 7'h20, 3'd5, 7'h3b};
			MN_MULW: return {2'd2, FMT_R, 7'h01, 3'd0, 7'h3b};
			MN_DIVW: return {2'd2, FMT_R, 7'h01, 3'd4, 7'h3b};
			MN_DIVUW: return {2'd2, FMT_R, 7'h01, 3'd5, 7'h3b};
			MN_REMW: return {2'd2, FMT_R, 7'h01, 3'd6, 7'h3b};
			MN_REMUW: return {2'd2, FMT_R, 7'h01, 3'd7, 7'h3b};
			default: return '0;
		endcase
	endfunction

	function automatic logic [31:0] mask_of(input logic [21:0] d);
		case (d[21:20])
			2'd0: return 32'h0000_007f;
			2'd1: return 32'h0000_707f;
			2'd2: return 32'hfe00_707f;
			default: return 32'hfc00_707f;
		endcase
	endfunction

	function automatic logic [31:0] value_of(input logic [21:0] d);
		return {d[16:10], 10'b0, d[9:7], 5'b0, d[6:0]} & mask_of(d);
	endfunction

	function automatic logic is_system(input insn_t w);
		logic counter;
		counter = w[31:20] inside {12'hc00, 12'hc01, 12'hc02, 12'hc80, 12'hc81, 12'hc82};
		return (w[6:0] == 7'h0f && w[14:13] == 2'b00) || w == 32'h0000_0073
			|| w == 32'h0010_0073
			|| (w[6:0] == 7'h73 && w[14:12] == 3'b010 && w[19:15] == 5'd0 && counter);
	endfunction

	function automatic trace_rec_t expected_record(input insn_t w);
		logic [21:0] d;
		mnem_t m;
		fmt_t f;
		flags_t fl;
		reg_idx_t rd;
		reg_idx_t rs1;
		reg_idx_t rs2;
		imm_t imm;
		m = MN_UNKNOWN;
		f = FMT_NONE;
		for (int k = 1; k <= 62; k++)
		begin
			d = encoding_of(mnem_t'(k));
			if ((w & mask_of(d)) == value_of(d))
			begin
				m = mnem_t'(k);
				f = d[19:17];
			end
		end
		if (is_system(w))
			m = MN_SYSTEM;
		fl[FLAG_LOAD] = (m >= MN_LB && m <= MN_LWU);
		fl[FLAG_MEM] = (m >= MN_LB && m <= MN_SD);
		fl[FLAG_SIGNED] = !(m inside {MN_BLTU, MN_BGEU, MN_SLTU, MN_SLTIU, MN_LBU, MN_LHU,
			MN_LWU, MN_MULHSU, MN_MULHU, MN_DIVU, MN_REMU, MN_DIVUW, MN_REMUW});
		rd = (f inside {FMT_R, FMT_I, FMT_U, FMT_J}) ? w[11:7] : 5'd0;
		rs1 = (f inside {FMT_R, FMT_I, FMT_S, FMT_B}) ? w[19:15] : 5'd0;
		rs2 = (f inside {FMT_R, FMT_S, FMT_B}) ? w[24:20] : 5'd0;
		case (f)
			FMT_I: imm = {{20{w[31]}}, w[31:20]};
			FMT_S: imm = {{20{w[31]}}, w[31:25], w[11:7]};
			FMT_B: imm = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
			FMT_U: imm = {w[31:12], 12'h000};
			FMT_J: imm = {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
			default: imm = '0;
		endcase
		return {4'b0000, m, f, fl, rd, rs1, rs2, imm};
	endfunction

	function automatic insn_t random_word();
		logic [31:0] r;
		logic [21:0] d;
		logic [1:0] sel;
		sel = 2'(take_bits(2));
		r = take_bits(32);
		if (sel == 2'd2)
			return r; // fully random, usually unknown.
		if (sel == 2'd3)
		begin
			case (2'(take_bits(2)))
				2'd0: return (r & ~32'h0000_607f) | 32'h0000_000f; // fence or fence.i.
				2'd1: return 32'h0000_0073;
				2'd2: return 32'h0010_0073;
				default: return {12'hc00 | 12'(take_bits(1) << 7) | 12'(take_bits(1)),
					5'd0, 3'b010, r[11:7], 7'h73};
			endcase
		end
		d = encoding_of(mnem_t'(1 + (take_bits(6) % 62)));
		return (r & ~mask_of(d)) | value_of(d);
	endfunction

	// instruction memory slave with random wait states.
	always @(posedge clk)
	begin
		if (!rst_n)
		begin
			imem_ack <= 1'b0;
			rd_wait <= rd_delay[0];
		end
		else if (imem_ack)
			imem_ack <= 1'b0;
		else if (imem_cyc && imem_stb)
		begin
			if (rd_wait != 0)
				rd_wait <= rd_wait - 1;
			else
			begin
				if (rd_count - rd_base >= run_count)
				begin
					$display("ERROR t=%0t: read beyond the run's word count", $time);
					err_rd <= err_rd + 1;
				end
				else if (imem_adr !== run_start + 32'(4 * (rd_count - rd_base)))
				begin
					$display("ERROR t=%0t imem_adr exp %h got %h", $time,
						run_start + 32'(4 * (rd_count - rd_base)), imem_adr);
					err_rd <= err_rd + 1;
				end
				if (imem_we !== 1'b0)
				begin
					$display("ERROR t=%0t imem_we exp 0 got %b", $time, imem_we);
					err_rd <= err_rd + 1;
				end
				imem_dat_r <= mem[imem_adr[9:2]];
				imem_ack <= 1'b1;
				rd_count <= rd_count + 1;
				rd_wait <= rd_delay[(rd_count + 1) % 512];
			end
		end
	end

	// trace memory slave that compares every record in order.
	always @(posedge clk)
	begin
		if (!rst_n)
		begin
			trc_ack <= 1'b0;
			wr_wait <= wr_delay[0];
		end
		else if (trc_ack)
			trc_ack <= 1'b0;
		else if (trc_cyc && trc_stb)
		begin
			if (wr_wait != 0)
				wr_wait <= wr_wait - 1;
			else
			begin
				if (wr_count - wr_base >= run_count)
				begin
					$display("ERROR t=%0t: trace write beyond the run's word count", $time);
					err_wr <= err_wr + 1;
				end
				else
				begin
					if (trc_adr !== `TRACE_BASE + 32'(8 * (wr_count - wr_base)))
					begin
						$display("ERROR t=%0t trc_adr exp %h got %h", $time,
							`TRACE_BASE + 32'(8 * (wr_count - wr_base)), trc_adr);
						err_wr <= err_wr + 1;
					end
					if (trc_dat_w !== exp_rec[wr_count - wr_base])
					begin
						$display("ERROR t=%0t trc_dat_w exp %h got %h", $time,
							exp_rec[wr_count - wr_base], trc_dat_w);
						err_wr <= err_wr + 1;
					end
				end
				if (trc_we !== 1'b1 || trc_sel !== 8'hff)
				begin
					$display("ERROR t=%0t trc_we/trc_sel exp 1/ff got %b/%h", $time,
						trc_we, trc_sel);
					err_wr <= err_wr + 1;
				end
				trc_ack <= 1'b1;
				wr_count <= wr_count + 1;
				wr_wait <= wr_delay[(wr_count + 1) % 512];
			end
		end
	end

	task automatic run(input logic [31:0] saddr, input int count);
		insn_t w;
		for (int i = 0; i < count; i++)
		begin
			w = random_word();
			mem[((saddr >> 2) + i) % 256] = w;
			exp_rec[i] = expected_record(w);
		end
		run_start = saddr;
		run_count = count;
		rd_base = rd_count;
		wr_base = wr_count;
		@(posedge clk);
		start <= 1'b1;
		start_addr <= saddr;
		insn_count <= `COUNT_W'(count);
		@(posedge clk);
		start <= 1'b0;
		@(negedge clk);
		if (!busy)
		begin
			$display("ERROR t=%0t busy exp 1 got 0", $time);
			err_ctl++;
		end
		if (count >= 4)
		begin
			@(posedge clk);
			start <= 1'b1; // must be ignored while busy.
			start_addr <= saddr + 32'h40;
			insn_count <= `COUNT_W'(3);
			@(posedge clk);
			start <= 1'b0;
		end
		do
			@(negedge clk);
		while (!done);
		if (busy)
		begin
			$display("ERROR t=%0t busy exp 0 got 1", $time);
			err_ctl++;
		end
		if (rd_count - rd_base != count || wr_count - wr_base != count)
		begin
			$display("ERROR t=%0t transfers exp %0d got %0d reads, %0d writes", $time,
				count, rd_count - rd_base, wr_count - wr_base);
			err_ctl++;
		end
		repeat (4)
		begin
			@(negedge clk);
			if (done || busy)
			begin
				$display("ERROR t=%0t: done or busy high after the run ended", $time);
				err_ctl++;
			end
		end
	endtask

	initial
	begin
		#(CLK_PERIOD * (40 * TOTAL_WORDS + 100));
		$display("timeout: the runs did not finish in time");
		$display("SOME TESTS FAILED");
		$finish;
	end

	initial
	begin
		clk = 1'b0;
		rst_n = 1'b0;
		start = 1'b0;
		start_addr = '0;
		insn_count = '0;
		run_start = '0;
		run_count = 0;
		rd_base = 0;
		wr_base = 0;
		for (int i = 0; i < 512; i++)
		begin
			rd_delay[i] = 2'(take_bits(2));
			wr_delay[i] = 2'(take_bits(2));
		end
		repeat (4) @(posedge clk);
		rst_n <= 1'b1;
		run(32'h8000_0000, 24);
		run(32'h8000_0100, 1);
		run(32'h8000_0200, 0);
		run(32'h8000_0300, 60);
		run(32'h8000_0010, 17);
		$display("errors: read %0d, trace %0d, control %0d, assertion %0d", err_rd, err_wr,
			err_ctl, DUT.u_props.fail_count);
		if (err_rd + err_wr + err_ctl + DUT.u_props.fail_count == 0)
			$display("ALL TESTS PASSED");
		else
			$display("SOME TESTS FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== project.f ====
+incdir+hw
hw/decode_pkg.sv
hw/insn_fetch.sv
hw/insn_classify.sv
hw/operand_extract.sv
hw/trace_writer.sv
hw/insn_decode_top.sv
verification/insn_decode_props.sv
verification/tb_insn_decode.sv

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f project.f --top-module tb_insn_decode -o sim_tb || exit 1
out=$(./obj_dir/sim_tb)
echo "$out"
echo "$out" | grep -q "ALL TESTS PASSED" && exit 0 || exit 1
